//--- rvOpcode_macros.svh
`ifndef RV_OPCODE_MACROS_SVH
`define RV_OPCODE_MACROS_SVH

// Opcode values of instruction bits 6 to 2
// Bits 1 and 0 are always 2'b11 for 32-bit RV32I words
`define opcodeLoad   5'b00000
`define opcodeStore  5'b01000
`define opcodeBranch 5'b11000
`define opcodeJalr   5'b11001
`define opcodeJal    5'b11011
`define opcodeR      5'b01100
`define opcodeI      5'b00100
`define opcodeAuipc  5'b00101
`define opcodeLui    5'b01101

// ALU select codes
// Other ALU ops come straight from {bit 30, funct3}
`define aluAdd       4'd0
`define aluPassB     4'd9

// Immediate formats for immGen
`define immI         3'd1
`define immS         3'd2
`define immB         3'd3
`define immU         3'd4
`define immJ         3'd5
`define immX         3'd6

// Memory access widths
// Loads use funct3 directly, this value marks no load at all
`define ldNone       3'd7

// Stores use funct3[1:0], this value marks no store
`define sNone        2'd3

// addi x0, x0, 0
`define nopInst      32'h0000_0013

`endif

//--- rvPkg.sv
package rvPkg;

   // R format: register to register ops
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rTypeFields;

   // I format: loads, JALR and register-immediate ops
   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iTypeFields;

   // S format, also the bit layout of B
   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sTypeFields;

   // U format, also the bit layout of J
   typedef struct packed {
      logic [19:0] immUpper;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uTypeFields;

   // One instruction word seen through every format at once
   typedef union packed {
      logic [31:0] raw;
      rTypeFields  r;
      iTypeFields  i;
      sTypeFields  s;
      uTypeFields  u;
   } instWord;

endpackage

//--- stageTracker.sv
`timescale 1ns/1ps

`include "rvOpcode_macros.svh"

module stageTracker
   import rvPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  instWord inst,
   output instWord exInst,
   output instWord wbInst
);

   // Two instruction registers, one per downstream stage
   // The whole word moves along so later decoders can pick any field
   always_ff @(posedge clk) begin
      if (rst) begin
         exInst.raw <= `nopInst;
         wbInst.raw <= `nopInst;
      end else begin
         exInst <= inst;
         wbInst <= exInst;
      end
   end

endmodule

//--- immGen.sv
`timescale 1ns/1ps

`include "rvOpcode_macros.svh"

module immGen
   import rvPkg::*;
(
   input  instWord     inst,
   output logic [2:0]  immSel,
   output logic [31:0] imm
);

   logic [4:0]  opcode;
   logic [6:0]  sHi;
   logic [4:0]  sLo;
   logic [19:0] upper;

   assign opcode = inst.r.opcode[6:2];
   assign sHi    = inst.s.immHi;
   assign sLo    = inst.s.immLo;
   assign upper  = inst.u.immUpper;

   // Format choice by opcode
   always_comb begin
      case (opcode)
         `opcodeLoad, `opcodeJalr, `opcodeI: immSel = `immI;
         `opcodeStore:                       immSel = `immS;
         `opcodeBranch:                      immSel = `immB;
         `opcodeJal:                         immSel = `immJ;
         `opcodeLui, `opcodeAuipc:           immSel = `immU;
         default:                            immSel = `immX;
      endcase
   end

   // Sign-extended immediate, sign bit is always inst[31]
   always_comb begin
      case (immSel)
         `immI: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
         `immS: imm = {{20{sHi[6]}}, sHi, sLo};
         // B reorders the S pieces, bit 0 is implied zero
         `immB: imm = {{19{sHi[6]}}, sHi[6], sLo[0], sHi[5:0], sLo[4:1], 1'b0};
         `immU: imm = {upper, 12'b0};
         // J reorders the U piece, bit 0 is implied zero
         `immJ: imm = {{11{upper[19]}}, upper[19], upper[7:0], upper[8], upper[18:9], 1'b0};
         default: imm = 32'd0;
      endcase
   end

endmodule

//--- exControl.sv
`timescale 1ns/1ps

`include "rvOpcode_macros.svh"

module exControl
   import rvPkg::*;
(
   input  instWord     inst,
   input  logic [31:0] rs1Val,
   input  logic [31:0] rs2Val,
   output logic        pcSel,
   output logic [1:0]  instSel,
   output logic        aSel,
   output logic        bSel,
   output logic [3:0]  aluSel,
   output logic        memRW,
   output logic [1:0]  sSel,
   output logic        usesRs1,
   output logic        usesRs2
);

   logic [4:0] opcode;
   logic [2:0] funct3;
   logic       brUn;
   logic       equal;
   logic       less;
   logic       brTaken;

   assign opcode = inst.r.opcode[6:2];
   assign funct3 = inst.r.funct3;

   // BLTU and BGEU are the only funct3 codes with both upper bits set
   assign brUn  = (funct3[2:1] == 2'b11);
   assign equal = (rs1Val == rs2Val);
   assign less  = brUn ? (rs1Val < rs2Val) : ($signed(rs1Val) < $signed(rs2Val));

   always_comb begin
      case (funct3)
         3'b000:         brTaken = equal;
         3'b001:         brTaken = !equal;
         3'b100, 3'b110: brTaken = less;
         3'b101, 3'b111: brTaken = !less;
         default:        brTaken = 1'b0;
      endcase
   end

   always_comb begin
      // Defaults match a NOP-like instruction with no side effects
      pcSel   = 1'b0;
      instSel = 2'd0;
      aSel    = 1'b0;
      bSel    = 1'b1;
      aluSel  = `aluAdd;
      memRW   = 1'b0;
      sSel    = `sNone;
      usesRs1 = 1'b0;
      usesRs2 = 1'b0;
      case (opcode)
         `opcodeR: begin
            bSel    = 1'b0;
            aluSel  = {inst.r.funct7[5], funct3};
            usesRs1 = 1'b1;
            usesRs2 = 1'b1;
         end
         `opcodeI: begin
            // Bit 30 picks SRAI over SRLI
            aluSel  = {inst.r.funct7[5], funct3};
            usesRs1 = 1'b1;
         end
         `opcodeLoad: begin
            memRW   = 1'b1;
            usesRs1 = 1'b1;
         end
         `opcodeStore: begin
            memRW   = 1'b1;
            sSel    = inst.s.funct3[1:0];
            usesRs1 = 1'b1;
            usesRs2 = 1'b1;
         end
         `opcodeBranch: begin
            // Target is PC plus immediate
            aSel    = 1'b1;
            instSel = 2'd2;
            pcSel   = brTaken;
            usesRs1 = 1'b1;
            usesRs2 = 1'b1;
         end
         `opcodeJal: begin
            aSel    = 1'b1;
            instSel = 2'd2;
            pcSel   = 1'b1;
         end
         `opcodeJalr: begin
            instSel = 2'd2;
            pcSel   = 1'b1;
            usesRs1 = 1'b1;
         end
         `opcodeAuipc: begin
            aSel = 1'b1;
         end
         `opcodeLui: begin
            aluSel = `aluPassB;
         end
         default: begin
         end
      endcase
   end

endmodule

//--- wbControl.sv
`timescale 1ns/1ps

`include "rvOpcode_macros.svh"

module wbControl
   import rvPkg::*;
(
   input  instWord    inst,
   output logic [2:0] ldSel,
   output logic [1:0] wbSel,
   output logic       regWrEn
);

   logic [4:0] opcode;
   logic       writesRd;

   assign opcode = inst.r.opcode[6:2];

   // wbSel: 0 memory, 1 ALU, 2 PC+4
   always_comb begin
      ldSel    = `ldNone;
      wbSel    = 2'd0;
      writesRd = 1'b0;
      case (opcode)
         `opcodeLoad: begin
            ldSel    = inst.i.funct3;
            writesRd = 1'b1;
         end
         `opcodeR, `opcodeI, `opcodeLui, `opcodeAuipc: begin
            wbSel    = 2'd1;
            writesRd = 1'b1;
         end
         `opcodeJal, `opcodeJalr: begin
            wbSel    = 2'd2;
            writesRd = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // Writes to x0 are dropped here so forwarding never sees them
   assign regWrEn = writesRd && (inst.r.rd != 5'd0);

endmodule

//--- forwardUnit.sv
`timescale 1ns/1ps

`include "rvOpcode_macros.svh"

module forwardUnit
   import rvPkg::*;
(
   input  logic       regWrEn,
   input  logic [4:0] wbRd,
   input  instWord    exInst,
   input  logic       exUsesRs1,
   input  logic       exUsesRs2,
   input  instWord    decInst,
   output logic       fwdA1,
   output logic       fwdB1,
   output logic       fwdA2,
   output logic       fwdB2
);

   logic [4:0] decOpcode;
   logic       decUsesRs1;
   logic       decUsesRs2;

   assign decOpcode = decInst.r.opcode[6:2];

   // Decode stage source usage, same rule as exControl applies one stage later
   always_comb begin
      decUsesRs1 = 1'b0;
      decUsesRs2 = 1'b0;
      case (decOpcode)
         `opcodeR, `opcodeStore, `opcodeBranch: begin
            decUsesRs1 = 1'b1;
            decUsesRs2 = 1'b1;
         end
         `opcodeI, `opcodeLoad, `opcodeJalr: begin
            decUsesRs1 = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // Writeback result into the decode stage operands
   assign fwdA1 = regWrEn && decUsesRs1 && (wbRd == decInst.r.rs1);
   assign fwdB1 = regWrEn && decUsesRs2 && (wbRd == decInst.r.rs2);

   // Writeback result into the execute stage operands
   assign fwdA2 = regWrEn && exUsesRs1 && (wbRd == exInst.r.rs1);
   assign fwdB2 = regWrEn && exUsesRs2 && (wbRd == exInst.r.rs2);

endmodule

//--- controlPath.sv
`timescale 1ns/1ps

module controlPath
   import rvPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  instWord     inst,
   input  logic [31:0] rs1Val,
   input  logic [31:0] rs2Val,
   output logic [31:0] imm,
   output logic        pcSel,
   output logic [1:0]  instSel,
   output logic        aSel,
   output logic        bSel,
   output logic [3:0]  aluSel,
   output logic        memRW,
   output logic [1:0]  sSel,
   output logic [2:0]  ldSel,
   output logic [1:0]  wbSel,
   output logic        regWrEn,
   output logic        fwdA1,
   output logic        fwdB1,
   output logic        fwdA2,
   output logic        fwdB2
);

   instWord exInst;
   instWord wbInst;
   logic    exUsesRs1;
   logic    exUsesRs2;

   stageTracker stageTracker_inst (
      .clk    (clk),
      .rst    (rst),
      .inst   (inst),
      .exInst (exInst),
      .wbInst (wbInst)
   );

   // Format code stays internal to the immediate generator
   immGen immGen_inst (
      .inst   (inst),
      .immSel (),
      .imm    (imm)
   );

   exControl exControl_inst (
      .inst    (exInst),
      .rs1Val  (rs1Val),
      .rs2Val  (rs2Val),
      .pcSel   (pcSel),
      .instSel (instSel),
      .aSel    (aSel),
      .bSel    (bSel),
      .aluSel  (aluSel),
      .memRW   (memRW),
      .sSel    (sSel),
      .usesRs1 (exUsesRs1),
      .usesRs2 (exUsesRs2)
   );

   wbControl wbControl_inst (
      .inst    (wbInst),
      .ldSel   (ldSel),
      .wbSel   (wbSel),
      .regWrEn (regWrEn)
   );

   forwardUnit forwardUnit_inst (
      .regWrEn   (regWrEn),
      .wbRd      (wbInst.r.rd),
      .exInst    (exInst),
      .exUsesRs1 (exUsesRs1),
      .exUsesRs2 (exUsesRs2),
      .decInst   (inst),
      .fwdA1     (fwdA1),
      .fwdB1     (fwdB1),
      .fwdA2     (fwdA2),
      .fwdB2     (fwdB2)
   );

endmodule

//--- controlPath_properties.sv
`timescale 1ns/1ps

module controlPath_properties
   import rvPkg::*;
(
   input logic    clk,
   input logic    rst,
   input instWord wbInst,
   input logic    memRW,
   input logic    pcSel,
   input logic    regWrEn,
   input logic    fwdA1,
   input logic    fwdB1,
   input logic    fwdA2,
   input logic    fwdB2
);

   // Writes to x0 never leave the writeback decoder
   noWriteX0: assert property (@(posedge clk) disable iff (rst)
      regWrEn |-> wbInst.r.rd != 5'd0)
      else $error("regWrEn is set while the writeback rd is x0");

   // Both stages hold the NOP right after reset
   quietAfterReset: assert property (@(posedge clk) rst |=> !memRW && !pcSel && !regWrEn)
      else $error("memRW, pcSel or regWrEn is set in the cycle after reset");

   noFwdWithoutWrite: assert property (@(posedge clk) disable iff (rst)
      !regWrEn |-> !(fwdA1 || fwdB1 || fwdA2 || fwdB2))
      else $error("a forwarding select is set while regWrEn is 0");

endmodule

bind controlPath controlPath_properties controlPath_properties_inst (
   .clk(clk), .rst(rst), .wbInst(wbInst), .memRW(memRW), .pcSel(pcSel), .regWrEn(regWrEn),
   .fwdA1(fwdA1), .fwdB1(fwdB1), .fwdA2(fwdA2), .fwdB2(fwdB2)
);

//--- controlPath_tb.sv
`timescale 1ns/1ps

`include "rvOpcode_macros.svh"

module controlPath_tb
   import rvPkg::*;
();

   localparam int timeoutCycles = 2000;

   logic        clk;
   logic        rst;
   instWord     inst;
   logic [31:0] rs1Val;
   logic [31:0] rs2Val;
   logic [31:0] imm;
   logic        pcSel;
   logic [1:0]  instSel;
   logic        aSel;
   logic        bSel;
   logic [3:0]  aluSel;
   logic        memRW;
   logic [1:0]  sSel;
   logic [2:0]  ldSel;
   logic [1:0]  wbSel;
   logic        regWrEn;
   logic        fwdA1;
   logic        fwdB1;
   logic        fwdA2;
   logic        fwdB2;
   int          errorCount = 0;
   int          checkCount = 0;
   int          cycleCount = 0;

   controlPath controlPath_inst (
      .clk(clk), .rst(rst), .inst(inst), .rs1Val(rs1Val), .rs2Val(rs2Val), .imm(imm),
      .pcSel(pcSel), .instSel(instSel), .aSel(aSel), .bSel(bSel), .aluSel(aluSel),
      .memRW(memRW), .sSel(sSel), .ldSel(ldSel), .wbSel(wbSel), .regWrEn(regWrEn),
      .fwdA1(fwdA1), .fwdB1(fwdB1), .fwdA2(fwdA2), .fwdB2(fwdB2)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles) begin
         $display("timeout: the tests did not finish within %0d cycles", timeoutCycles);
         $display("** FAIL **");
         $finish;
      end
   end

   // Instruction encoders following the RV32I bit layouts
   function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, `opcodeR, 2'b11};
   endfunction

   function automatic logic [31:0] encI(logic [11:0] im, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [4:0] opc);
      return {im, rs1, f3, rd, opc, 2'b11};
   endfunction

   function automatic logic [31:0] encS(logic [11:0] im, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
      return {im[11:5], rs2, rs1, f3, im[4:0], `opcodeStore, 2'b11};
   endfunction

   function automatic logic [31:0] encB(logic [12:0] im, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
      return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], `opcodeBranch, 2'b11};
   endfunction

   function automatic logic [31:0] encJ(logic [20:0] im, logic [4:0] rd);
      return {im[20], im[10:1], im[11], im[19:12], rd, `opcodeJal, 2'b11};
   endfunction

   function automatic logic brTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         3'd7: return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   task automatic stepOps(logic [31:0] word, logic [31:0] a, logic [31:0] b);
      @(posedge clk);
      inst <= word;
      rs1Val <= a;
      rs2Val <= b;
      @(negedge clk);
   endtask

   task automatic stepInst(logic [31:0] word);
      stepOps(word, $urandom(), $urandom());
   endtask

   task automatic checkImm(string name, logic [31:0] expVal, logic [31:0] actVal);
      checkCount++;
      if (actVal !== expVal) begin
         errorCount++;
         $display("error %s: expected %h, actual %h", name, expVal, actVal);
      end
   endtask

   // Packed as {pcSel, instSel, aSel, bSel, aluSel, memRW, sSel}
   task automatic checkExCtrl(string name, logic [11:0] expVal, logic [11:0] actVal);
      checkCount++;
      if (actVal !== expVal) begin
         errorCount++;
         $display("error %s: expected %h, actual %h", name, expVal, actVal);
      end
   endtask

   // Packed as {ldSel, wbSel, regWrEn}
   task automatic checkWbCtrl(string name, logic [5:0] expVal, logic [5:0] actVal);
      checkCount++;
      if (actVal !== expVal) begin
         errorCount++;
         $display("error %s: expected %h, actual %h", name, expVal, actVal);
      end
   endtask

   // Packed as {fwdA1, fwdB1, fwdA2, fwdB2}
   task automatic checkFwd(string name, logic [3:0] expVal, logic [3:0] actVal);
      checkCount++;
      if (actVal !== expVal) begin
         errorCount++;
         $display("error %s: expected %h, actual %h", name, expVal, actVal);
      end
   endtask

   task automatic testReset();
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      inst <= `nopInst;
      @(negedge clk);
      checkImm("reset imm", 32'd0, imm);
      checkExCtrl("reset ex", {1'b0, 2'd0, 1'b0, 1'b1, `aluAdd, 1'b0, `sNone},
                  {pcSel, instSel, aSel, bSel, aluSel, memRW, sSel});
      // The NOP is an I-type op, so wbSel points at the ALU
      checkWbCtrl("reset wb", {`ldNone, 2'd1, 1'b0}, {ldSel, wbSel, regWrEn});
      checkFwd("reset fwd", 4'b0000, {fwdA1, fwdB1, fwdA2, fwdB2});
   endtask

   task automatic testImm();
      logic [31:0] r;
      for (int k = 0; k < 8; k++) begin
         r = $urandom();
         stepInst(encI(r[11:0], r[16:12], 3'b010, r[21:17], k[0] ? `opcodeLoad : `opcodeI));
         checkImm("imm I", {{20{r[11]}}, r[11:0]}, imm);
         stepInst(encS(r[11:0], r[16:12], r[21:17], 3'b010));
         checkImm("imm S", {{20{r[11]}}, r[11:0]}, imm);
         stepInst(encB({r[12:1], 1'b0}, r[17:13], r[22:18], 3'b001));
         checkImm("imm B", {{19{r[12]}}, r[12:1], 1'b0}, imm);
         stepInst({r[31:12], r[11:7], k[0] ? `opcodeAuipc : `opcodeLui, 2'b11});
         checkImm("imm U", {r[31:12], 12'd0}, imm);
         stepInst(encJ({r[20:1], 1'b0}, r[11:7]));
         checkImm("imm J", {{11{r[20]}}, r[20:1], 1'b0}, imm);
      end
      stepInst(32'hdead_be7f);
      checkImm("imm X", 32'd0, imm);
   endtask

   // Execute controls one cycle later and writeback controls two cycles later
   task automatic pipeCheck(string name, logic [31:0] word, logic [11:0] expEx,
                            logic [5:0] expWb);
      stepInst(word);
      stepInst(`nopInst);
      checkExCtrl(name, expEx, {pcSel, instSel, aSel, bSel, aluSel, memRW, sSel});
      stepInst(`nopInst);
      checkWbCtrl(name, expWb, {ldSel, wbSel, regWrEn});
   endtask

   task automatic testDecode();
      pipeCheck("sub", encR(7'h20, 5'd3, 5'd2, 3'b000, 5'd1),
                {1'b0, 2'd0, 1'b0, 1'b0, 4'h8, 1'b0, `sNone}, {`ldNone, 2'd1, 1'b1});
      pipeCheck("srai", encI(12'h405, 5'd1, 3'b101, 5'd4, `opcodeI),
                {1'b0, 2'd0, 1'b0, 1'b1, 4'hd, 1'b0, `sNone}, {`ldNone, 2'd1, 1'b1});
      pipeCheck("lbu", encI(12'h010, 5'd2, 3'b100, 5'd5, `opcodeLoad),
                {1'b0, 2'd0, 1'b0, 1'b1, `aluAdd, 1'b1, `sNone}, {3'd4, 2'd0, 1'b1});
      pipeCheck("sh", encS(12'hff0, 5'd6, 5'd7, 3'b001),
                {1'b0, 2'd0, 1'b0, 1'b1, `aluAdd, 1'b1, 2'd1}, {`ldNone, 2'd0, 1'b0});
      pipeCheck("lui", {20'h12345, 5'd8, `opcodeLui, 2'b11},
                {1'b0, 2'd0, 1'b0, 1'b1, `aluPassB, 1'b0, `sNone}, {`ldNone, 2'd1, 1'b1});
      pipeCheck("auipc", {20'hfedcb, 5'd9, `opcodeAuipc, 2'b11},
                {1'b0, 2'd0, 1'b1, 1'b1, `aluAdd, 1'b0, `sNone}, {`ldNone, 2'd1, 1'b1});
      pipeCheck("jal", encJ(21'h000100, 5'd10),
                {1'b1, 2'd2, 1'b1, 1'b1, `aluAdd, 1'b0, `sNone}, {`ldNone, 2'd2, 1'b1});
      pipeCheck("jalr", encI(12'h004, 5'd1, 3'b000, 5'd11, `opcodeJalr),
                {1'b1, 2'd2, 1'b0, 1'b1, `aluAdd, 1'b0, `sNone}, {`ldNone, 2'd2, 1'b1});
      pipeCheck("addi x0", encI(12'h001, 5'd3, 3'b000, 5'd0, `opcodeI),
                {1'b0, 2'd0, 1'b0, 1'b1, `aluAdd, 1'b0, `sNone}, {`ldNone, 2'd1, 1'b0});
      pipeCheck("unknown", 32'h0000_0f7f,
                {1'b0, 2'd0, 1'b0, 1'b1, `aluAdd, 1'b0, `sNone}, {`ldNone, 2'd0, 1'b0});
   endtask

   task automatic testBranch();
      logic [2:0]  f3List [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      for (int f = 0; f < 6; f++) begin
         for (int p = 0; p < 4; p++) begin
            r = $urandom();
            a = $urandom();
            b = (p == 1) ? a : $urandom();
            if (p >= 2) begin
               // Opposite signs make the signed and unsigned orders disagree
               a = (p == 2) ? (r | 32'h8000_0000) : (r & 32'h7fff_ffff);
               b = ~a;
            end
            stepInst(encB(13'h0010, 5'd2, 5'd1, f3List[f]));
            stepOps(`nopInst, a, b);
            checkExCtrl("branch", {brTaken(f3List[f], a, b), 2'd2, 1'b1, 1'b1, `aluAdd,
                        1'b0, `sNone}, {pcSel, instSel, aSel, bSel, aluSel, memRW, sSel});
            stepInst(`nopInst);
            checkWbCtrl("branch wb", {`ldNone, 2'd0, 1'b0}, {ldSel, wbSel, regWrEn});
         end
      end
   endtask

   // Producer reaches writeback while c1 is in execute and c2 in decode
   task automatic fwdCase(string name, logic [31:0] prod, logic [31:0] c1, logic [31:0] c2,
                          logic [3:0] expFwd);
      stepInst(prod);
      stepInst(c1);
      stepInst(c2);
      checkFwd(name, expFwd, {fwdA1, fwdB1, fwdA2, fwdB2});
   endtask

   task automatic testFwd();
      logic [31:0] p;
      p = encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd5);
      fwdCase("fwd rs1 ex rs2 dec", p, encR(7'h00, 5'd3, 5'd5, 3'b000, 5'd6),
              encR(7'h20, 5'd5, 5'd4, 3'b000, 5'd7), 4'b0110);
      fwdCase("fwd store dec addi", p, encS(12'h008, 5'd5, 5'd1, 3'b010),
              encI(12'h001, 5'd5, 3'b000, 5'd8, `opcodeI), 4'b1001);
      fwdCase("fwd both", p, encR(7'h00, 5'd5, 5'd5, 3'b000, 5'd6),
              encB(13'h0010, 5'd5, 5'd5, 3'b000), 4'b1111);
      // Immediate bits that line up with rs fields must not forward
      fwdCase("fwd i rs2 lui", p, encI(12'h005, 5'd1, 3'b000, 5'd9, `opcodeI),
              {20'h00528, 5'd10, `opcodeLui, 2'b11}, 4'b0000);
      fwdCase("fwd lui i rs2", p, {20'h00528, 5'd11, `opcodeLui, 2'b11},
              encI(12'h005, 5'd2, 3'b000, 5'd12, `opcodeI), 4'b0000);
      fwdCase("fwd x0", encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd0),
              encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd6), encB(13'h0, 5'd0, 5'd0, 3'b001), 4'b0000);
      fwdCase("fwd load", encI(12'h000, 5'd1, 3'b010, 5'd5, `opcodeLoad),
              encR(7'h00, 5'd3, 5'd5, 3'b000, 5'd6), encS(12'h005, 5'd1, 5'd2, 3'b010), 4'b0010);
   endtask

   initial begin
      clk = 1'b0;
      rst <= 1'b1;
      // A writing R op sits on inst during reset and must not reach the stages
      inst <= encR(7'h20, 5'd1, 5'd1, 3'b000, 5'd1);
      rs1Val <= 32'd0;
      rs2Val <= 32'd0;
      void'($urandom(32'h1224_a10f));
      testReset();
      testImm();
      testDecode();
      testBranch();
      testFwd();
      $display("checks run %0d, errors %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- sim.f
+incdir+.
rvPkg.sv
stageTracker.sv
immGen.sv
exControl.sv
wbControl.sv
forwardUnit.sv
controlPath.sv
controlPath_properties.sv
controlPath_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the controlPath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module controlPath_tb -o controlPath_sim

output=$(./obj_dir/controlPath_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qF '** PASS **'; then
   exit 0
fi
exit 1
